//--- src/permuterPkg.sv
package permuterPkg;

    // Producer lanes feeding the permuter
    localparam int numLanes = 2;

    // Per-lane batch buffer, 64 words
    localparam int laneAddrLog2 = 6;
    localparam int laneSlowMargin = 16;

    // Batch-size queue
    localparam int sizeFifoLog2 = 4;
    localparam int sizeFifoAlmostFull = 12;

    // Permuter input FIFO
    localparam int inputFifoLog2 = 5;
    localparam int inputFifoSlowLevel = 16;

    // Pipeline latencies in cycles
    localparam int bufferReadLatency = 2;
    localparam int permuterLatency = 2;

    // Truth table of a 7-variable function
    typedef logic [127:0] botT;

    // Bit 5 is ABC down to bit 0 which is CBA
    typedef logic [5:0] permMaskT;

    typedef logic [5:0] batchSizeT;

    typedef logic [numLanes-1:0] laneMaskT;

    typedef enum logic {
        idle,
        issuing
    } permStateT;

endpackage

//--- src/syncFifo.sv
module syncFifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH_LOG2 = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  writeEnable,
    input  logic [WIDTH-1:0]      dataIn,
    input  logic                  readEnable,
    output logic [WIDTH-1:0]      dataOut,
    output logic                  empty,
    output logic [DEPTH_LOG2:0]   usedw
);

    logic [WIDTH-1:0] mem [1 << DEPTH_LOG2];
    logic [DEPTH_LOG2-1:0] writePtr;
    logic [DEPTH_LOG2-1:0] readPtr;

    always_ff @(posedge clk) begin
        if (rst) begin
            writePtr <= '0;
            readPtr <= '0;
            usedw <= '0;
        end else begin
            if (writeEnable) begin
                writePtr <= writePtr + 1'b1;
            end
            if (readEnable) begin
                readPtr <= readPtr + 1'b1;
            end
            case ({writeEnable, readEnable})
                2'b10: usedw <= usedw + 1'b1;
                2'b01: usedw <= usedw - 1'b1;
                default: usedw <= usedw;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (writeEnable) begin
            mem[writePtr] <= dataIn;
        end
    end

    // Head word is shown without a read request
    assign dataOut = mem[readPtr];
    assign empty = (usedw == '0);

    // Top bit of the count is set only when full
    assert property (@(posedge clk) disable iff (rst) writeEnable |-> !usedw[DEPTH_LOG2])
        else $error("syncFifo: write while full");

    assert property (@(posedge clk) disable iff (rst) readEnable |-> !empty)
        else $error("syncFifo: read while empty");

endmodule

//--- src/batchBotBuffer.sv
module batchBotBuffer (
    input  logic                   clk,
    input  logic                   rst,
    input  permuterPkg::botT       botIn,
    input  permuterPkg::permMaskT  maskIn,
    input  logic                   endBatch,
    output permuterPkg::batchSizeT batchSize,
    input  logic                   read,
    output permuterPkg::botT       botOut,
    output permuterPkg::permMaskT  maskOut,
    output logic                   slowDown
);

    logic write;
    logic [permuterPkg::laneAddrLog2-1:0] writeAddr;
    logic [permuterPkg::laneAddrLog2-1:0] readAddr;
    logic [permuterPkg::laneAddrLog2-1:0] spareWords;
    permuterPkg::batchSizeT batchCount;
    logic readPending;
    logic [$bits(permuterPkg::botT)+$bits(permuterPkg::permMaskT)-1:0]
        mem [1 << permuterPkg::laneAddrLog2];

    // Zero-mask bots are dropped
    assign write = |maskIn;

    // Closing bot counts toward its own batch
    assign batchSize = batchCount + permuterPkg::batchSizeT'(write);

    // readAddr points at the last word read, so this is one less than free
    assign spareWords = readAddr - writeAddr;

    always_ff @(posedge clk) begin
        if (rst) begin
            writeAddr <= '0;
            readAddr <= '1;
            batchCount <= '0;
            readPending <= 1'b0;
            slowDown <= 1'b0;
        end else begin
            if (write) begin
                writeAddr <= writeAddr + 1'b1;
            end
            if (read) begin
                readAddr <= readAddr + 1'b1;
            end
            batchCount <= endBatch ? '0 : batchSize;
            readPending <= read;
            slowDown <= spareWords < permuterPkg::laneSlowMargin - 1;
        end
    end

    always_ff @(posedge clk) begin
        if (write) begin
            mem[writeAddr] <= {botIn, maskIn};
        end
        // Second read stage, address was registered the cycle before
        if (readPending) begin
            {botOut, maskOut} <= mem[readAddr];
        end
    end

endmodule

//--- src/botPermuter.sv
module botPermuter (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  permuterPkg::botT      botIn,
    input  permuterPkg::permMaskT maskIn,
    output logic                  done,
    output logic                  permutedBotValid,
    output permuterPkg::botT      permutedBot
);

    permuterPkg::permStateT state;
    permuterPkg::botT curBot;
    permuterPkg::permMaskT pending;
    logic [2:0] selIdx;
    logic lastBit;

    // Rearranges index bits A=6, B=5, C=4 of every truth table entry
    function automatic permuterPkg::botT permuteBot(
        input permuterPkg::botT b,
        input logic [2:0] sel
    );
        permuterPkg::botT r;
        logic [6:0] src;
        r = '0;
        for (int i = 0; i < $bits(permuterPkg::botT); i++) begin
            src = 7'(i);
            case (sel)
                3'd4: src[6:4] = {src[6], src[4], src[5]};
                3'd3: src[6:4] = {src[5], src[6], src[4]};
                3'd2: src[6:4] = {src[5], src[4], src[6]};
                3'd1: src[6:4] = {src[4], src[6], src[5]};
                3'd0: src[6:4] = {src[4], src[5], src[6]};
                default: src[6:4] = src[6:4];
            endcase
            r[i] = b[src];
        end
        return r;
    endfunction

    // Highest pending bit goes first
    always_comb begin
        selIdx = '0;
        for (int k = 0; k < $bits(permuterPkg::permMaskT); k++) begin
            if (pending[k]) begin
                selIdx = 3'(k);
            end
        end
    end

    assign lastBit = (pending & (pending - 1'b1)) == '0;
    assign done = (state == permuterPkg::idle) || lastBit;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= permuterPkg::idle;
            pending <= '0;
            permutedBotValid <= 1'b0;
        end else begin
            permutedBotValid <= (state == permuterPkg::issuing);
            if (start) begin
                pending <= maskIn;
            end else if (state == permuterPkg::issuing) begin
                pending <= pending & ~(permuterPkg::permMaskT'(1) << selIdx);
            end
            // A batchDone word carries no mask and leaves the generator idle
            if (done) begin
                state <= (start && maskIn != '0) ? permuterPkg::issuing : permuterPkg::idle;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            curBot <= botIn;
        end
        if (state == permuterPkg::issuing) begin
            permutedBot <= permuteBot(curBot, selIdx);
        end
    end

    assert property (@(posedge clk) disable iff (rst) start |-> done)
        else $error("botPermuter: start while still issuing");

endmodule

//--- src/batchScheduler.sv
interface botStreamIf;
    logic                  write;
    permuterPkg::botT      bot;
    permuterPkg::permMaskT mask;
    logic                  batchDone;
    logic                  slowDown;

    modport source (
        output write,
        output bot,
        output mask,
        output batchDone,
        input  slowDown
    );

    modport sink (
        input  write,
        input  bot,
        input  mask,
        input  batchDone,
        output slowDown
    );
endinterface

module batchScheduler (
    input  logic                   clk,
    input  logic                   rst,
    input  permuterPkg::laneMaskT  batchesDone,
    input  permuterPkg::batchSizeT batchSizes [permuterPkg::numLanes],
    output permuterPkg::laneMaskT  readLanes,
    input  permuterPkg::botT       laneBots [permuterPkg::numLanes],
    input  permuterPkg::permMaskT  laneMasks [permuterPkg::numLanes],
    input  permuterPkg::laneMaskT  laneSlowDowns,
    output permuterPkg::laneMaskT  slowDownInputs,
    botStreamIf.source             stream
);

    permuterPkg::batchSizeT closeSize;
    permuterPkg::batchSizeT headSize;
    permuterPkg::laneMaskT headLane;
    logic queueEmpty;
    logic [permuterPkg::sizeFifoLog2:0] queueUsed;
    logic queueAlmostFull;
    permuterPkg::batchSizeT remaining;
    permuterPkg::laneMaskT activeLane;
    logic batchIdle;
    logic startBatch;
    logic pushRead;
    logic wasActive;
    permuterPkg::laneMaskT arrivePipe [permuterPkg::bufferReadLatency];
    logic [permuterPkg::bufferReadLatency-1:0] endPipe;

    always_comb begin
        closeSize = '0;
        for (int l = 0; l < permuterPkg::numLanes; l++) begin
            closeSize = closeSize | (batchesDone[l] ? batchSizes[l] : '0);
        end
    end

    // Records are {size, one-hot origin lane} in close order
    syncFifo #(
        .WIDTH($bits(permuterPkg::batchSizeT) + permuterPkg::numLanes),
        .DEPTH_LOG2(permuterPkg::sizeFifoLog2)
    ) i_sizeQueue (
        .clk(clk),
        .rst(rst),
        .writeEnable(|batchesDone),
        .dataIn({closeSize, batchesDone}),
        .readEnable(startBatch),
        .dataOut({headSize, headLane}),
        .empty(queueEmpty),
        .usedw(queueUsed)
    );

    assign batchIdle = (remaining == '0);
    assign startBatch = batchIdle && !queueEmpty;
    assign pushRead = !batchIdle && !stream.slowDown;
    assign readLanes = pushRead ? activeLane : '0;

    // A full size queue holds back every lane
    assign slowDownInputs = queueAlmostFull ? '1 : laneSlowDowns;

    always_ff @(posedge clk) begin
        if (rst) begin
            queueAlmostFull <= 1'b0;
            remaining <= '0;
            activeLane <= '0;
            wasActive <= 1'b0;
        end else begin
            queueAlmostFull <= queueUsed >= permuterPkg::sizeFifoAlmostFull;
            wasActive <= !batchIdle || startBatch;
            if (startBatch) begin
                remaining <= headSize;
                activeLane <= headLane;
            end else if (pushRead) begin
                remaining <= remaining - 1'b1;
            end
        end
    end

    // Lane of each read follows the data through the buffer latency
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < permuterPkg::bufferReadLatency; k++) begin
                arrivePipe[k] <= '0;
            end
            endPipe <= '0;
        end else begin
            arrivePipe[0] <= readLanes;
            for (int k = 1; k < permuterPkg::bufferReadLatency; k++) begin
                arrivePipe[k] <= arrivePipe[k-1];
            end
            endPipe <= {endPipe[permuterPkg::bufferReadLatency-2:0], wasActive && batchIdle};
        end
    end

    // Nothing selected on a batchDone word, so bot and mask stay zero
    always_comb begin
        stream.bot = '0;
        stream.mask = '0;
        for (int l = 0; l < permuterPkg::numLanes; l++) begin
            if (arrivePipe[permuterPkg::bufferReadLatency-1][l]) begin
                stream.bot = stream.bot | laneBots[l];
                stream.mask = stream.mask | laneMasks[l];
            end
        end
    end

    assign stream.batchDone = endPipe[permuterPkg::bufferReadLatency-1];
    assign stream.write = |arrivePipe[permuterPkg::bufferReadLatency-1] || stream.batchDone;

    // Size selection above relies on lanes closing in distinct cycles
    assert property (@(posedge clk) disable iff (rst) $onehot0(batchesDone))
        else $error("batchScheduler: two lanes closed a batch in one cycle");

endmodule

//--- src/botPermuterWithFifo.sv
module botPermuterWithFifo (
    input  logic             clk,
    input  logic             rst,
    botStreamIf.sink         stream,
    input  logic             requestSlowDown,
    output permuterPkg::botT permutedBot,
    output logic             permutedBotValid,
    output logic             batchFinished
);

    permuterPkg::botT headBot;
    permuterPkg::permMaskT headMask;
    logic headDone;
    logic fifoEmpty;
    logic [permuterPkg::inputFifoLog2:0] fifoUsed;
    logic permuterDone;
    logic grab;
    logic [permuterPkg::permuterLatency-1:0] finishPipe;

    // Slow-down only holds back new bots, one in progress runs to the end
    assign grab = permuterDone && !fifoEmpty && !requestSlowDown;

    syncFifo #(
        .WIDTH($bits(permuterPkg::botT) + $bits(permuterPkg::permMaskT) + 1),
        .DEPTH_LOG2(permuterPkg::inputFifoLog2)
    ) i_inputFifo (
        .clk(clk),
        .rst(rst),
        .writeEnable(stream.write),
        .dataIn({stream.bot, stream.mask, stream.batchDone}),
        .readEnable(grab),
        .dataOut({headBot, headMask, headDone}),
        .empty(fifoEmpty),
        .usedw(fifoUsed)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            stream.slowDown <= 1'b0;
            finishPipe <= '0;
        end else begin
            // Level leaves room for words still in the buffer read pipeline
            stream.slowDown <= fifoUsed >= permuterPkg::inputFifoSlowLevel;
            finishPipe <= {finishPipe[permuterPkg::permuterLatency-2:0], grab && headDone};
        end
    end

    // Lines up with the generator latency
    assign batchFinished = finishPipe[permuterPkg::permuterLatency-1];

    botPermuter i_botPermuter (
        .clk(clk),
        .rst(rst),
        .start(grab),
        .botIn(headBot),
        .maskIn(headMask),
        .done(permuterDone),
        .permutedBotValid(permutedBotValid),
        .permutedBot(permutedBot)
    );

endmodule

//--- src/multiLanePermuterTop.sv
module multiLanePermuterTop (
    input  logic                  clk,
    input  logic                  rst,
    input  permuterPkg::botT      laneBot [permuterPkg::numLanes],
    input  permuterPkg::permMaskT laneMask [permuterPkg::numLanes],
    input  permuterPkg::laneMaskT laneBatchDone,
    output permuterPkg::laneMaskT slowDownInputs,
    output permuterPkg::botT      permutedBot,
    output logic                  permutedBotValid,
    output logic                  batchFinished,
    input  logic                  requestSlowDown
);

    permuterPkg::batchSizeT batchSizes [permuterPkg::numLanes];
    permuterPkg::laneMaskT readLanes;
    permuterPkg::botT laneBots [permuterPkg::numLanes];
    permuterPkg::permMaskT laneMasks [permuterPkg::numLanes];
    permuterPkg::laneMaskT laneSlowDowns;

    botStreamIf stream ();

    for (genvar l = 0; l < permuterPkg::numLanes; l++) begin : gLane
        batchBotBuffer i_batchBotBuffer (
            .clk(clk),
            .rst(rst),
            .botIn(laneBot[l]),
            .maskIn(laneMask[l]),
            .endBatch(laneBatchDone[l]),
            .batchSize(batchSizes[l]),
            .read(readLanes[l]),
            .botOut(laneBots[l]),
            .maskOut(laneMasks[l]),
            .slowDown(laneSlowDowns[l])
        );
    end

    batchScheduler i_batchScheduler (
        .clk(clk),
        .rst(rst),
        .batchesDone(laneBatchDone),
        .batchSizes(batchSizes),
        .readLanes(readLanes),
        .laneBots(laneBots),
        .laneMasks(laneMasks),
        .laneSlowDowns(laneSlowDowns),
        .slowDownInputs(slowDownInputs),
        .stream(stream)
    );

    botPermuterWithFifo i_botPermuterWithFifo (
        .clk(clk),
        .rst(rst),
        .stream(stream),
        .requestSlowDown(requestSlowDown),
        .permutedBot(permutedBot),
        .permutedBotValid(permutedBotValid),
        .batchFinished(batchFinished)
    );

endmodule

//--- dv/permuterTb.sv
module permuterTb;

    // Wide margin over the combined length of all tests
    localparam int timeoutCycles = 20000;
    localparam int pressureBots = 60;
    localparam int maxOutputsAfterSlowDown = 6;
    // 49 stored words leave fewer than 16 free and the registered flag lets one more in
    localparam int writesBeforeSlowDown = 50;

    logic clk;
    logic rst;
    permuterPkg::botT laneBot [permuterPkg::numLanes];
    permuterPkg::permMaskT laneMask [permuterPkg::numLanes];
    permuterPkg::laneMaskT laneBatchDone;
    permuterPkg::laneMaskT slowDownInputs;
    permuterPkg::botT permutedBot;
    logic permutedBotValid;
    logic batchFinished;
    logic requestSlowDown;

    // Bit 128 marks a batchFinished entry
    logic [128:0] expQ [$];
    logic [128:0] pend0 [$];
    logic [128:0] pend1 [$];
    logic [128:0] head;
    logic [31:0] rngState;
    int validCount;
    int cycleCount;

    multiLanePermuterTop i_multiLanePermuterTop (
        .clk(clk),
        .rst(rst),
        .laneBot(laneBot),
        .laneMask(laneMask),
        .laneBatchDone(laneBatchDone),
        .slowDownInputs(slowDownInputs),
        .permutedBot(permutedBot),
        .permutedBotValid(permutedBotValid),
        .batchFinished(batchFinished),
        .requestSlowDown(requestSlowDown)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic reportFailure(string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped after a failed check");
    endtask

    task automatic checkValue(string name, logic [127:0] actual, logic [127:0] expected);
        if (actual !== expected) begin
            reportFailure($sformatf("mismatch %s got 0x%0h expected 0x%0h",
                name, actual, expected));
        end
    endtask

    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic permuterPkg::botT randomBot();
        return {nextRandom(), nextRandom(), nextRandom(), nextRandom()};
    endfunction

    function automatic permuterPkg::permMaskT randomMask();
        logic [31:0] r;
        r = nextRandom();
        return (r[5:0] == '0) ? 6'h21 : r[5:0];
    endfunction

    // p counts ABC=0 up to CBA=5, index bits 6,5,4 are A,B,C
    function automatic permuterPkg::botT refPermute(permuterPkg::botT bot, int p);
        permuterPkg::botT result;
        logic [6:0] idx;
        logic [6:0] j;
        logic a;
        logic b;
        logic c;
        result = '0;
        for (int i = 0; i < 128; i++) begin
            idx = 7'(i);
            a = idx[6];
            b = idx[5];
            c = idx[4];
            j = idx;
            case (p)
                1: j[6:4] = {a, c, b};
                2: j[6:4] = {b, a, c};
                3: j[6:4] = {b, c, a};
                4: j[6:4] = {c, a, b};
                5: j[6:4] = {c, b, a};
                default: j[6:4] = {a, b, c};
            endcase
            result[i] = bot[j];
        end
        return result;
    endfunction

    // Drives one lane for the current cycle and tracks the expected stream
    task automatic setLane(int lane, permuterPkg::botT bot, permuterPkg::permMaskT mask,
                           logic done);
        laneBot[lane] = bot;
        laneMask[lane] = mask;
        laneBatchDone[lane] = done;
        for (int p = 0; p < 6; p++) begin
            if (mask[5-p]) begin
                if (lane == 0) begin
                    pend0.push_back({1'b0, refPermute(bot, p)});
                end else begin
                    pend1.push_back({1'b0, refPermute(bot, p)});
                end
            end
        end
        if (done) begin
            if (lane == 0) begin
                while (pend0.size() != 0) expQ.push_back(pend0.pop_front());
            end else begin
                while (pend1.size() != 0) expQ.push_back(pend1.pop_front());
            end
            expQ.push_back({1'b1, 128'h0});
        end
    endtask

    task automatic clearInputs();
        for (int l = 0; l < permuterPkg::numLanes; l++) begin
            laneBot[l] = '0;
            laneMask[l] = '0;
        end
        laneBatchDone = '0;
    endtask

    task automatic nextSlot();
        @(posedge clk);
        #10;
        clearInputs();
    endtask

    task automatic waitDrained();
        nextSlot();
        while (expQ.size() != 0) begin
            @(posedge clk);
        end
        // Extra cycles let stray outputs show up
        repeat (20) @(posedge clk);
    endtask

    task automatic sendFullMask();
        nextSlot();
        setLane(0, randomBot(), 6'h3F, 1'b0);
        nextSlot();
        setLane(0, '0, '0, 1'b1);
        waitDrained();
    endtask

    task automatic mixRandomMasks();
        logic [31:0] r;
        for (int n = 0; n < 20; n++) begin
            r = nextRandom();
            nextSlot();
            // Roughly one bot in four has an empty mask
            setLane(1, randomBot(), (r[9:8] == 2'b00) ? 6'h00 : r[5:0], 1'b0);
        end
        nextSlot();
        setLane(1, '0, '0, 1'b1);
        waitDrained();
    endtask

    task automatic alternateLanes();
        // Lane 0 closes at cycles 3 and 6, lane 1 at cycle 5
        for (int c = 0; c < 7; c++) begin
            nextSlot();
            if (c == 3 || c == 6) begin
                setLane(0, '0, '0, 1'b1);
            end else begin
                setLane(0, randomBot(), randomMask(), 1'b0);
            end
            if (c < 5) begin
                setLane(1, randomBot(), randomMask(), 1'b0);
            end else if (c == 5) begin
                setLane(1, '0, '0, 1'b1);
            end
        end
        waitDrained();
    endtask

    task automatic closeEmptyBatch();
        nextSlot();
        setLane(1, '0, '0, 1'b1);
        waitDrained();
    endtask

    task automatic holdDownstream();
        int written;
        int v0;
        written = 0;
        nextSlot();
        requestSlowDown = 1'b1;
        v0 = validCount;
        while (written < pressureBots && !slowDownInputs[0]) begin
            nextSlot();
            if (!slowDownInputs[0]) begin
                setLane(0, randomBot(), randomMask(), 1'b0);
                written++;
            end
        end
        if (!slowDownInputs[0]) begin
            reportFailure("slowDownInputs for lane 0 did not rise with a full lane buffer");
        end
        checkValue("slowDownInputs", slowDownInputs, 2'b01);
        checkValue("lane 0 writes before slowDownInputs", written, writesBeforeSlowDown);
        nextSlot();
        setLane(0, '0, '0, 1'b1);
        repeat (50) nextSlot();
        if (validCount - v0 > maxOutputsAfterSlowDown) begin
            reportFailure("outputs kept coming while requestSlowDown was high");
        end
        requestSlowDown = 1'b0;
        while (written < pressureBots) begin
            nextSlot();
            if (!slowDownInputs[0]) begin
                setLane(0, randomBot(), randomMask(), 1'b0);
                written++;
            end
        end
        nextSlot();
        setLane(0, '0, '0, 1'b1);
        waitDrained();
    endtask

    // Outputs change on the rising edge
    always @(negedge clk) begin
        if (!rst) begin
            if (permutedBotValid) begin
                if (expQ.size() == 0) begin
                    reportFailure("permutedBotValid high with no result expected");
                end else if (expQ[0][128]) begin
                    reportFailure("permuted bot arrived where batchFinished was expected");
                end else begin
                    head = expQ.pop_front();
                    checkValue("permutedBot", permutedBot, head[127:0]);
                    validCount++;
                end
            end
            if (batchFinished) begin
                if (expQ.size() == 0) begin
                    reportFailure("batchFinished high with no batch expected");
                end else if (!expQ[0][128]) begin
                    reportFailure("batchFinished arrived while results are still expected");
                end else begin
                    head = expQ.pop_front();
                end
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= timeoutCycles) begin
            reportFailure("timeout, the run did not finish within the cycle limit");
        end
    end

    initial begin
        rngState = 32'd55070;
        validCount = 0;
        cycleCount = 0;
        rst = 1'b1;
        requestSlowDown = 1'b0;
        clearInputs();
        repeat (16) @(posedge clk);
        #10;
        rst = 1'b0;
        checkValue("slowDownInputs", slowDownInputs, 2'b00);
        checkValue("permutedBotValid", permutedBotValid, 1'b0);
        checkValue("batchFinished", batchFinished, 1'b0);

        sendFullMask();
        mixRandomMasks();
        alternateLanes();
        closeEmptyBatch();
        holdDownstream();

        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- all.f
src/permuterPkg.sv
src/syncFifo.sv
src/batchBotBuffer.sv
src/botPermuter.sv
src/batchScheduler.sv
src/botPermuterWithFifo.sv
src/multiLanePermuterTop.sv
dv/permuterTb.sv

//--- Bender.yml
package:
  name: multi_lane_permuter

sources:
  - src/permuterPkg.sv
  - src/syncFifo.sv
  - src/batchBotBuffer.sv
  - src/botPermuter.sv
  - src/batchScheduler.sv
  - src/botPermuterWithFifo.sv
  - src/multiLanePermuterTop.sv
  - target: test
    files:
      - dv/permuterTb.sv
